// ==== common/cpu_dbg_pkg.sv ====
package cpu_dbg_pkg;

    typedef logic [31:0] word_t;      // Data, address or instruction word.
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  imem_addr_t; // Word index into instruction memory.
    typedef logic [7:0]  dbg_cmd_t;
    typedef logic [3:0]  op_t;

    localparam int IMEM_DEPTH = 256;
    localparam int CP0_REGS   = 8;
    localparam int CP0_IDX_W  = $clog2(CP0_REGS);

    // Host command codes.
    localparam dbg_cmd_t CMD_STOP      = 8'd1;
    localparam dbg_cmd_t CMD_CONT      = 8'd2;
    localparam dbg_cmd_t CMD_EN_BP     = 8'd3;
    localparam dbg_cmd_t CMD_DIS_BP    = 8'd4;
    localparam dbg_cmd_t CMD_SET_BP    = 8'd5;
    localparam dbg_cmd_t CMD_READ_REG  = 8'd6;
    localparam dbg_cmd_t CMD_READ_CP0  = 8'd7;
    localparam dbg_cmd_t CMD_READ_HI   = 8'd8;
    localparam dbg_cmd_t CMD_READ_LO   = 8'd9;
    localparam dbg_cmd_t CMD_READ_PC   = 8'd10;
    localparam dbg_cmd_t CMD_RESET     = 8'd11;
    localparam dbg_cmd_t CMD_READ_IMEM = 8'd12;

    // Opcodes sit in instruction bits 31..28. Unknown values run as NOP.
    localparam op_t OP_NOP  = 4'd0;
    localparam op_t OP_ADDI = 4'd1;
    localparam op_t OP_MULT = 4'd2;
    localparam op_t OP_MTC0 = 4'd3;

    typedef enum logic [1:0] {
        DBG_RUN,
        DBG_TRIGGER,
        DBG_WAIT_PIPELINE,
        DBG_STOPPED
    } dbg_state_t;

endpackage

// ==== core/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_dbg_pkg::reg_addr_t rs_addr,
    input  cpu_dbg_pkg::reg_addr_t rt_addr,
    input  logic                   wr_en,
    input  cpu_dbg_pkg::reg_addr_t wr_addr,
    input  cpu_dbg_pkg::word_t     wr_data,
    input  cpu_dbg_pkg::reg_addr_t main_reg_addr,
    output cpu_dbg_pkg::word_t     rs_data,
    output cpu_dbg_pkg::word_t     rt_data,
    output cpu_dbg_pkg::word_t     main_reg_value
);

    cpu_dbg_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data; // Register 0 stays zero.
        end
    end

    assign rs_data        = regs[rs_addr];
    assign rt_data        = regs[rt_addr];
    assign main_reg_value = regs[main_reg_addr];

endmodule

// ==== core/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_dbg_pkg::word_t      fetch_data,
    input  logic                    flush,
    input  cpu_dbg_pkg::word_t      new_pc_value,
    input  logic                    debug_stall,
    input  logic                    pc_reset,
    output cpu_dbg_pkg::imem_addr_t fetch_addr,
    output cpu_dbg_pkg::word_t      pc_reg_value,
    output cpu_dbg_pkg::word_t      inst,
    output cpu_dbg_pkg::word_t      inst_pc,
    output logic                    inst_valid
);

    cpu_dbg_pkg::imem_addr_t pc;
    cpu_dbg_pkg::imem_addr_t pc_next;
    logic                    fetch_ok; // fetch_data holds the word at pc.
    logic                    advance;

    assign advance = fetch_ok && !debug_stall;

    // Memory is addressed with the next PC so its output lines up with pc.
    always_comb begin
        if (pc_reset)
            pc_next = '0;
        else if (flush)
            pc_next = cpu_dbg_pkg::imem_addr_t'(new_pc_value);
        else if (advance)
            pc_next = pc + 1'b1;
        else
            pc_next = pc;
    end

    assign fetch_addr   = pc_next;
    assign pc_reg_value = cpu_dbg_pkg::word_t'(pc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= '0;
            fetch_ok   <= 1'b0;
            inst_pc    <= '0;
            inst_valid <= 1'b0;
        end else begin
            fetch_ok <= 1'b1;
            pc       <= pc_next;
            if (pc_reset) begin
                inst_pc    <= '0;
                inst_valid <= 1'b0;
            end else if (flush) begin
                inst_valid <= 1'b0; // inst_pc already equals the new PC.
            end else if (advance) begin
                inst_pc    <= cpu_dbg_pkg::word_t'(pc);
                inst_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !flush && !pc_reset)
            inst <= fetch_data;
    end

endmodule

// ==== core/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_dbg_pkg::word_t     inst,
    input  logic                   inst_valid,
    input  logic                   flush,
    input  logic                   debug_stall,
    input  cpu_dbg_pkg::word_t     rs_data,
    input  cpu_dbg_pkg::word_t     rt_data,
    input  cpu_dbg_pkg::reg_addr_t cp0_reg_addr,
    output cpu_dbg_pkg::reg_addr_t rs_addr,
    output cpu_dbg_pkg::reg_addr_t rt_addr,
    output logic                   wr_en,
    output cpu_dbg_pkg::reg_addr_t wr_addr,
    output cpu_dbg_pkg::word_t     wr_data,
    output logic [63:0]            hilo_reg_value,
    output cpu_dbg_pkg::word_t     cp0_reg_value
);

    cpu_dbg_pkg::op_t       op;
    cpu_dbg_pkg::reg_addr_t rd;
    cpu_dbg_pkg::word_t     imm;
    logic                   exec_en;
    logic                   mult_en;
    logic                   mtc0_en;
    logic [63:0]            product;
    cpu_dbg_pkg::word_t     hi;
    cpu_dbg_pkg::word_t     lo;
    cpu_dbg_pkg::word_t     cp0 [cpu_dbg_pkg::CP0_REGS];

    assign op      = inst[31:28];
    assign rd      = inst[27:23];
    assign rs_addr = inst[22:18];
    assign rt_addr = inst[17:13];
    assign imm     = {{16{inst[15]}}, inst[15:0]};

    // Nothing retires while the debugger squashes or holds the pipe.
    assign exec_en = inst_valid && !flush && !debug_stall;

    always_comb begin
        wr_en   = 1'b0;
        mult_en = 1'b0;
        mtc0_en = 1'b0;
        case (op)
            cpu_dbg_pkg::OP_NOP:  ;
            cpu_dbg_pkg::OP_ADDI: wr_en = exec_en;
            cpu_dbg_pkg::OP_MULT: mult_en = exec_en;
            cpu_dbg_pkg::OP_MTC0: mtc0_en = exec_en;
            default: ;
        endcase
    end

    assign wr_addr = rd;
    assign wr_data = rs_data + imm;
    assign product = 64'(rs_data) * 64'(rt_data); // Unsigned.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (mult_en) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_dbg_pkg::CP0_REGS; i++)
                cp0[i] <= '0;
        end else if (mtc0_en) begin
            cp0[rd[cpu_dbg_pkg::CP0_IDX_W-1:0]] <= rs_data; // rd modulo 8.
        end
    end

    assign hilo_reg_value = {hi, lo};

    // Indices past the implemented set read as zero.
    always_comb begin
        if (cp0_reg_addr < cpu_dbg_pkg::CP0_REGS)
            cp0_reg_value = cp0[cp0_reg_addr[cpu_dbg_pkg::CP0_IDX_W-1:0]];
        else
            cp0_reg_value = '0;
    end

endmodule

// ==== dbg/dbg_ctl.sv ====
`timescale 1ns/1ps

module dbg_ctl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_dbg_pkg::word_t     inst_pc_value,
    input  logic                   inst_valid,
    input  cpu_dbg_pkg::word_t     main_reg_value,
    input  cpu_dbg_pkg::word_t     cp0_reg_value,
    input  logic [63:0]            hilo_reg_value,
    input  cpu_dbg_pkg::word_t     pc_reg_value,
    input  cpu_dbg_pkg::word_t     debugger_mem_data,
    input  cpu_dbg_pkg::dbg_cmd_t  host_cmd,
    input  cpu_dbg_pkg::word_t     host_param,
    input  logic                   host_cmd_en,
    output cpu_dbg_pkg::word_t     new_pc_value,
    output logic                   flush,
    output logic                   debug_stall,
    output cpu_dbg_pkg::reg_addr_t main_reg_addr,
    output cpu_dbg_pkg::reg_addr_t cp0_reg_addr,
    output logic                   pc_reset,
    output logic                   debugger_mem_read,
    output cpu_dbg_pkg::imem_addr_t debugger_mem_addr,
    output cpu_dbg_pkg::word_t     host_result
);

    cpu_dbg_pkg::word_t      breakpoint;
    logic                    breakpoint_en;
    logic                    breakpoint_trig;
    logic                    command_stop;
    logic                    command_cont;
    cpu_dbg_pkg::dbg_state_t dbg_state;

    // Read addresses come straight from the command parameter.
    assign main_reg_addr     = host_param[4:0];
    assign cp0_reg_addr      = host_param[4:0];
    assign debugger_mem_addr = host_param[7:0];
    assign debugger_mem_read = host_cmd_en && (host_cmd == cpu_dbg_pkg::CMD_READ_IMEM);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            breakpoint    <= '1;
            breakpoint_en <= 1'b0;
            command_stop  <= 1'b0;
            command_cont  <= 1'b0;
            pc_reset      <= 1'b0;
            host_result   <= '0;
        end else begin
            command_stop <= 1'b0; // Pulses last one cycle.
            command_cont <= 1'b0;
            pc_reset     <= 1'b0;
            host_result  <= '0;
            if (host_cmd_en) begin
                case (host_cmd)
                    cpu_dbg_pkg::CMD_STOP:      command_stop <= 1'b1;
                    cpu_dbg_pkg::CMD_CONT:      command_cont <= 1'b1;
                    cpu_dbg_pkg::CMD_EN_BP:     breakpoint_en <= 1'b1;
                    cpu_dbg_pkg::CMD_DIS_BP:    breakpoint_en <= 1'b0;
                    cpu_dbg_pkg::CMD_SET_BP:    breakpoint <= host_param;
                    cpu_dbg_pkg::CMD_READ_REG:  host_result <= main_reg_value;
                    cpu_dbg_pkg::CMD_READ_CP0:  host_result <= cp0_reg_value;
                    cpu_dbg_pkg::CMD_READ_HI:   host_result <= hilo_reg_value[63:32];
                    cpu_dbg_pkg::CMD_READ_LO:   host_result <= hilo_reg_value[31:0];
                    cpu_dbg_pkg::CMD_READ_PC:   host_result <= pc_reg_value;
                    cpu_dbg_pkg::CMD_RESET:     pc_reset <= 1'b1;
                    cpu_dbg_pkg::CMD_READ_IMEM: host_result <= debugger_mem_data;
                    default: ;
                endcase
            end
        end
    end

    assign breakpoint_trig = breakpoint_en && inst_valid && (breakpoint == inst_pc_value);

    // The squashed instruction is where the core restarts.
    assign new_pc_value = inst_pc_value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dbg_state <= cpu_dbg_pkg::DBG_RUN;
        end else begin
            case (dbg_state)
                cpu_dbg_pkg::DBG_RUN: begin
                    if (breakpoint_trig || command_stop)
                        dbg_state <= cpu_dbg_pkg::DBG_TRIGGER;
                end
                cpu_dbg_pkg::DBG_TRIGGER: begin
                    dbg_state <= cpu_dbg_pkg::DBG_WAIT_PIPELINE;
                end
                cpu_dbg_pkg::DBG_WAIT_PIPELINE: begin
                    dbg_state <= cpu_dbg_pkg::DBG_STOPPED;
                end
                cpu_dbg_pkg::DBG_STOPPED: begin
                    if (command_cont)
                        dbg_state <= cpu_dbg_pkg::DBG_RUN;
                end
                default: dbg_state <= cpu_dbg_pkg::DBG_RUN;
            endcase
        end
    end

    always_comb begin
        flush       = 1'b0;
        debug_stall = 1'b0;
        case (dbg_state)
            cpu_dbg_pkg::DBG_RUN: begin
                flush = breakpoint_trig || command_stop;
            end
            cpu_dbg_pkg::DBG_TRIGGER,
            cpu_dbg_pkg::DBG_WAIT_PIPELINE,
            cpu_dbg_pkg::DBG_STOPPED: begin
                debug_stall = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/imem.sv ====
`timescale 1ns/1ps

module imem (
    input  logic                    clk,
    input  logic                    prog_we,
    input  cpu_dbg_pkg::imem_addr_t prog_addr,
    input  cpu_dbg_pkg::word_t      prog_data,
    input  cpu_dbg_pkg::imem_addr_t fetch_addr,
    input  logic                    debugger_mem_read,
    input  cpu_dbg_pkg::imem_addr_t debugger_mem_addr,
    output cpu_dbg_pkg::word_t      fetch_data,
    output cpu_dbg_pkg::word_t      debugger_mem_data
);

    cpu_dbg_pkg::word_t mem [cpu_dbg_pkg::IMEM_DEPTH];

    // Load port and registered fetch read.
    always_ff @(posedge clk) begin
        if (prog_we)
            mem[prog_addr] <= prog_data;
        fetch_data <= mem[fetch_addr];
    end

    assign debugger_mem_data = debugger_mem_read ? mem[debugger_mem_addr] : '0;

endmodule

// ==== rtl/cpu_dbg_top.sv ====
`timescale 1ns/1ps

module cpu_dbg_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    prog_we,
    input  cpu_dbg_pkg::imem_addr_t prog_addr,
    input  cpu_dbg_pkg::word_t      prog_data,
    input  cpu_dbg_pkg::dbg_cmd_t   host_cmd,
    input  cpu_dbg_pkg::word_t      host_param,
    input  logic                    host_cmd_en,
    output cpu_dbg_pkg::word_t      host_result,
    output logic                    debug_stall
);

    cpu_dbg_pkg::imem_addr_t fetch_addr;
    cpu_dbg_pkg::word_t      fetch_data;
    cpu_dbg_pkg::word_t      pc_reg_value;
    cpu_dbg_pkg::word_t      inst;
    cpu_dbg_pkg::word_t      inst_pc;
    logic                    inst_valid;

    cpu_dbg_pkg::reg_addr_t  rs_addr;
    cpu_dbg_pkg::reg_addr_t  rt_addr;
    cpu_dbg_pkg::word_t      rs_data;
    cpu_dbg_pkg::word_t      rt_data;
    logic                    wr_en;
    cpu_dbg_pkg::reg_addr_t  wr_addr;
    cpu_dbg_pkg::word_t      wr_data;

    logic                    flush;
    logic                    pc_reset;
    cpu_dbg_pkg::word_t      new_pc_value;
    cpu_dbg_pkg::reg_addr_t  main_reg_addr;
    cpu_dbg_pkg::word_t      main_reg_value;
    cpu_dbg_pkg::reg_addr_t  cp0_reg_addr;
    cpu_dbg_pkg::word_t      cp0_reg_value;
    logic [63:0]             hilo_reg_value;
    logic                    debugger_mem_read;
    cpu_dbg_pkg::imem_addr_t debugger_mem_addr;
    cpu_dbg_pkg::word_t      debugger_mem_data;

    fetch_stage u_fetch (
        .clk, .rst_n, .fetch_data, .flush, .new_pc_value, .debug_stall, .pc_reset,
        .fetch_addr, .pc_reg_value, .inst, .inst_pc, .inst_valid
    );

    exec_stage u_exec (
        .clk, .rst_n, .inst, .inst_valid, .flush, .debug_stall, .rs_data, .rt_data,
        .cp0_reg_addr, .rs_addr, .rt_addr, .wr_en, .wr_addr, .wr_data,
        .hilo_reg_value, .cp0_reg_value
    );

    regfile u_regfile (
        .clk, .rst_n, .rs_addr, .rt_addr, .wr_en, .wr_addr, .wr_data, .main_reg_addr,
        .rs_data, .rt_data, .main_reg_value
    );

    imem u_imem (
        .clk, .prog_we, .prog_addr, .prog_data, .fetch_addr, .debugger_mem_read,
        .debugger_mem_addr, .fetch_data, .debugger_mem_data
    );

    dbg_ctl u_dbg (
        .clk,
        .rst_n,
        .inst_pc_value (inst_pc),
        .inst_valid,
        .main_reg_value,
        .cp0_reg_value,
        .hilo_reg_value,
        .pc_reg_value,
        .debugger_mem_data,
        .host_cmd,
        .host_param,
        .host_cmd_en,
        .new_pc_value,
        .flush,
        .debug_stall,
        .main_reg_addr,
        .cp0_reg_addr,
        .pc_reset,
        .debugger_mem_read,
        .debugger_mem_addr,
        .host_result
    );

endmodule

// ==== test/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Architectural state as the program should leave it.
cpu_dbg_pkg::word_t model_regs [32];
cpu_dbg_pkg::word_t model_hi;
cpu_dbg_pkg::word_t model_lo;
cpu_dbg_pkg::word_t model_cp0 [8];
cpu_dbg_pkg::word_t prog_mem [cpu_dbg_pkg::IMEM_DEPTH]; // Loaded image.

int check_count = 0;
int error_count = 0;

function automatic void clear_model();
    for (int i = 0; i < 32; i++)
        model_regs[i] = '0;
    for (int i = 0; i < 8; i++)
        model_cp0[i] = '0;
    model_hi = '0;
    model_lo = '0;
endfunction

// Executes the word at one address on the model state.
function automatic void apply_inst(input int addr);
    cpu_dbg_pkg::word_t w;
    cpu_dbg_pkg::word_t imm;
    logic [63:0]        prod;
    int                 rd;
    int                 rs;
    int                 rt;
    w    = prog_mem[addr % cpu_dbg_pkg::IMEM_DEPTH];
    rd   = w[27:23];
    rs   = w[22:18];
    rt   = w[17:13];
    imm  = {{16{w[15]}}, w[15:0]};
    prod = {32'd0, model_regs[rs]} * {32'd0, model_regs[rt]};
    case (w[31:28])
        cpu_dbg_pkg::OP_ADDI: if (rd != 0) model_regs[rd] = model_regs[rs] + imm;
        cpu_dbg_pkg::OP_MULT: begin
            model_hi = prod[63:32];
            model_lo = prod[31:0];
        end
        cpu_dbg_pkg::OP_MTC0: model_cp0[rd % 8] = model_regs[rs];
        default: ; // NOP and unused opcodes.
    endcase
endfunction

function automatic void advance_model(input int from_pc, input int to_pc);
    for (int a = from_pc; a < to_pc; a++)
        apply_inst(a);
endfunction

task automatic check_value(input cpu_dbg_pkg::word_t actual,
                           input cpu_dbg_pkg::word_t expected, input string what);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
endtask

`endif

// ==== test/tb_cpu_dbg.sv ====
`timescale 1ns/1ps

module tb_cpu_dbg;

    localparam int PROG_LEN   = 40;
    localparam int MAX_CYCLES = 20000; // The whole sequence needs under 2000 cycles.

    logic                    clk;
    logic                    rst_n;
    logic                    prog_we;
    cpu_dbg_pkg::imem_addr_t prog_addr;
    cpu_dbg_pkg::word_t      prog_data;
    cpu_dbg_pkg::dbg_cmd_t   host_cmd;
    cpu_dbg_pkg::word_t      host_param;
    logic                    host_cmd_en;
    cpu_dbg_pkg::word_t      host_result;
    logic                    debug_stall;

    integer seed;
    int     cycle_count = 0;
    int     stop_pc; // Address the model has executed up to.

    `include "tb_model.svh"

    cpu_dbg_top UUT (
        .clk, .rst_n, .prog_we, .prog_addr, .prog_data,
        .host_cmd, .host_param, .host_cmd_en, .host_result, .debug_stall
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic make_program();
        int                 a;
        int                 sel;
        cpu_dbg_pkg::word_t fields;
        for (a = 0; a < cpu_dbg_pkg::IMEM_DEPTH; a++)
            prog_mem[a] = '0;
        for (a = 0; a < PROG_LEN; a++) begin
            sel    = $unsigned($random(seed)) % 4;
            fields = $random(seed);
            case (sel)
                0, 1:    prog_mem[a] = {cpu_dbg_pkg::OP_ADDI, fields[27:0]};
                2:       prog_mem[a] = {cpu_dbg_pkg::OP_MULT, fields[27:0]};
                default: prog_mem[a] = {cpu_dbg_pkg::OP_MTC0, fields[27:0]};
            endcase
        end
    endtask

    // One strobe, then the registered result a cycle later.
    task automatic host_command(input cpu_dbg_pkg::dbg_cmd_t cmd,
                                input cpu_dbg_pkg::word_t param,
                                output cpu_dbg_pkg::word_t result);
        @(posedge clk);
        host_cmd    <= cmd;
        host_param  <= param;
        host_cmd_en <= 1'b1;
        @(posedge clk);
        host_cmd_en <= 1'b0;
        @(negedge clk);
        result = host_result;
    endtask

    task automatic host_write(input cpu_dbg_pkg::dbg_cmd_t cmd, input cpu_dbg_pkg::word_t param);
        cpu_dbg_pkg::word_t unused;
        host_command(cmd, param, unused);
    endtask

    task automatic continue_run();
        host_write(cpu_dbg_pkg::CMD_CONT, '0);
        do @(negedge clk); while (debug_stall);
    endtask

    task automatic wait_stopped();
        do @(negedge clk); while (!debug_stall);
        repeat (2) @(posedge clk); // Drain through to the stopped state.
    endtask

    task automatic compare_state(input string label);
        cpu_dbg_pkg::word_t value;
        int                 i;
        for (i = 0; i < 32; i++) begin
            host_command(cpu_dbg_pkg::CMD_READ_REG, i, value);
            check_value(value, model_regs[i], $sformatf("%s, register %0d", label, i));
        end
        host_command(cpu_dbg_pkg::CMD_READ_HI, '0, value);
        check_value(value, model_hi, {label, ", HI"});
        host_command(cpu_dbg_pkg::CMD_READ_LO, '0, value);
        check_value(value, model_lo, {label, ", LO"});
        for (i = 0; i < 32; i++) begin
            host_command(cpu_dbg_pkg::CMD_READ_CP0, i, value);
            check_value(value, (i < 8) ? model_cp0[i % 8] : '0,
                        $sformatf("%s, CP0 %0d", label, i));
        end
        check_value(32'(debug_stall), 1, {label, ", debug_stall held while stopped"});
    endtask

    initial begin
        cpu_dbg_pkg::word_t pc;
        cpu_dbg_pkg::word_t value;
        int                 addr;
        int                 round;
        clk         = 1'b0;
        rst_n       = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        host_cmd    = '0;
        host_param  = '0;
        host_cmd_en = 1'b0;
        seed        = 70;
        make_program();
        clear_model();

        for (addr = 0; addr < cpu_dbg_pkg::IMEM_DEPTH; addr++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= cpu_dbg_pkg::imem_addr_t'(addr);
            prog_data <= prog_mem[addr];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Early stop, then run into the breakpoint at 25.
        host_write(cpu_dbg_pkg::CMD_STOP, '0);
        wait_stopped();
        host_command(cpu_dbg_pkg::CMD_READ_PC, '0, pc);
        check_value(32'(pc < 25), 1, "first stop lies before the breakpoint");
        advance_model(0, pc);
        stop_pc = pc;
        compare_state("stop after reset");
        host_write(cpu_dbg_pkg::CMD_SET_BP, 25);
        host_write(cpu_dbg_pkg::CMD_EN_BP, '0);
        continue_run();
        wait_stopped();
        host_command(cpu_dbg_pkg::CMD_READ_PC, '0, pc);
        check_value(pc, 25, "PC at breakpoint 25");
        advance_model(stop_pc, 25);
        stop_pc = 25;
        compare_state("breakpoint 25");

        // Words inside the program, then three past its end.
        for (addr = 0; addr < 23; addr++) begin
            pc = (addr < 20) ? ($unsigned($random(seed)) % PROG_LEN) : 200 + addr;
            host_command(cpu_dbg_pkg::CMD_READ_IMEM, pc, value);
            check_value(value, prog_mem[pc[7:0]], $sformatf("imem word %0d", pc));
        end

        host_write(cpu_dbg_pkg::CMD_DIS_BP, '0);
        for (round = 0; round < 2; round++) begin
            continue_run();
            repeat (3 + $unsigned($random(seed)) % 13) @(posedge clk);
            host_write(cpu_dbg_pkg::CMD_STOP, '0);
            wait_stopped();
            host_command(cpu_dbg_pkg::CMD_READ_PC, '0, pc);
            check_value(32'(pc > stop_pc), 1, "PC advanced before STOP");
            advance_model(stop_pc, pc);
            stop_pc = pc;
            compare_state($sformatf("STOP round %0d", round));
        end

        // Restart at 0 without clearing state.
        host_write(cpu_dbg_pkg::CMD_RESET, '0);
        host_command(cpu_dbg_pkg::CMD_READ_PC, '0, pc);
        check_value(pc, 0, "PC after RESET");
        host_write(cpu_dbg_pkg::CMD_SET_BP, 10);
        host_write(cpu_dbg_pkg::CMD_EN_BP, '0);
        continue_run();
        wait_stopped();
        host_command(cpu_dbg_pkg::CMD_READ_PC, '0, pc);
        check_value(pc, 10, "PC at breakpoint 10");
        advance_model(0, 10);
        compare_state("breakpoint 10 after RESET");

        host_write(cpu_dbg_pkg::CMD_DIS_BP, '0);
        host_write(cpu_dbg_pkg::CMD_RESET, '0);
        host_write(cpu_dbg_pkg::CMD_SET_BP, 5);
        continue_run();
        repeat (15) @(posedge clk);
        host_write(cpu_dbg_pkg::CMD_STOP, '0);
        wait_stopped();
        host_command(cpu_dbg_pkg::CMD_READ_PC, '0, pc);
        check_value(32'(pc > 5), 1, "run passed the disabled breakpoint");
        advance_model(0, pc);
        compare_state("disabled breakpoint");

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+test
common/cpu_dbg_pkg.sv
core/regfile.sv
core/fetch_stage.sv
core/exec_stage.sv
dbg/dbg_ctl.sv
rtl/imem.sv
rtl/cpu_dbg_top.sv
test/tb_cpu_dbg.sv

// ==== Bender.yml ====
package:
  name: cpu_dbg

sources:
  - common/cpu_dbg_pkg.sv
  - core/regfile.sv
  - core/fetch_stage.sv
  - core/exec_stage.sv
  - dbg/dbg_ctl.sv
  - rtl/imem.sv
  - rtl/cpu_dbg_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_cpu_dbg.sv
